//--- verilog/ddr5_pkg.sv
`default_nettype none

package ddr5_pkg;

	localparam int NUM_SLOTS  = 4;
	localparam int BURST_LEN  = 16;
	localparam int DATA_W     = 16;
	localparam int INDEX_W    = 5;
	localparam int T_RCD      = 4;  // act p2 to column p1
	localparam int RD_TO_DATA = 11; // read p2 to beat 0 on dq_in
	localparam int WR_TO_DATA = 8;  // write p2 to beat 0 on dq_out

	localparam int SLOT_W  = $clog2(NUM_SLOTS);
	localparam int BEAT_W  = $clog2(BURST_LEN);
	localparam int FREE_W  = $clog2(NUM_SLOTS + 1); // holds 0..NUM_SLOTS
	localparam int TIMER_W = $clog2(RD_TO_DATA + 1); // longest wait is the read latency
	localparam int CA_W    = 14;

	// ca opcodes in the p1 word
	localparam logic [1:0] OP_ACT = 2'b00;
	localparam logic [4:0] OP_RD  = 5'b10111;
	localparam logic [4:0] OP_WR  = 5'b10110;
	localparam logic [4:0] OP_PRE = 5'b11011; // preceded by a 1 in ca[13]

	typedef enum logic {kind_read, kind_write} req_kind_t;

	typedef enum logic [2:0] {
		slot_empty, slot_filling, slot_full, slot_busy, slot_returning
	} slot_state_t;

	typedef enum logic [2:0] {
		cmd_nop, cmd_activate, cmd_read, cmd_write, cmd_precharge
	} dram_cmd_t;

	typedef struct packed {
		logic [1:0]  bank_group;
		logic [1:0]  bank;
		logic [15:0] row;
		logic [9:0]  column; // low BEAT_W bits pick the beat
	} dram_addr_t;

	// dram_addr_t minus the beat bits, same bit order
	typedef struct packed {
		logic [1:0]  bank_group;
		logic [1:0]  bank;
		logic [15:0] row;
		logic [5:0]  col_group;
	} burst_addr_t;

	typedef struct packed {
		dram_addr_t          addr;
		req_kind_t           kind;
		logic [DATA_W-1:0]   data;  // ignored for reads
		logic [INDEX_W-1:0]  index;
	} arb_req_t;

	typedef struct packed {
		req_kind_t           kind;
		logic [INDEX_W-1:0]  index;
		logic [DATA_W-1:0]   data;
	} ret_t;

	typedef struct packed {
		req_kind_t   kind;
		burst_addr_t addr;
	} slot_info_t;

endpackage

`default_nettype wire

//--- verilog/burst_collector.sv
`timescale 1ns/1ps
`default_nettype none

module burst_collector (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               arbiter_valid,
	input  ddr5_pkg::arb_req_t                 arb_req,
	input  logic [ddr5_pkg::SLOT_W-1:0]        sel_slot,
	input  logic                               start_pulse,
	input  logic                               done_pulse,
	input  logic                               rd_beat_we,
	input  logic [ddr5_pkg::BEAT_W-1:0]        beat_num,
	input  logic [ddr5_pkg::DATA_W-1:0]        dq_in,
	output logic [ddr5_pkg::FREE_W-1:0]        free_slots,
	output logic [ddr5_pkg::NUM_SLOTS-1:0]     full,
	output ddr5_pkg::slot_info_t               slot_info,
	output logic [ddr5_pkg::DATA_W-1:0]        wr_beat_data,
	output logic                               wr_beat_mask,
	output logic                               ret_valid,
	output ddr5_pkg::ret_t                     ret
);
	import ddr5_pkg::*;

	typedef struct packed {
		slot_state_t                        state;
		req_kind_t                          kind;
		burst_addr_t                        addr;
		logic [BURST_LEN-1:0]               mask; // beats holding a request
		logic [BURST_LEN-1:0][INDEX_W-1:0]  index;
		logic [BURST_LEN-1:0][DATA_W-1:0]   data;
	} slot_t;

	slot_t slot_q [NUM_SLOTS];

	logic [SLOT_W-1:0]    fill_slot; // slot taking merges
	logic                 fill_open;
	logic [SLOT_W-1:0]    new_slot;
	logic [SLOT_W-1:0]    wr_slot;
	logic                 merge;
	burst_addr_t          req_key;
	logic [BEAT_W-1:0]    req_beat;
	logic [SLOT_W-1:0]    drain_slot;
	logic                 drain_any;
	logic [BURST_LEN-1:0] low_bit;
	logic [BEAT_W-1:0]    ret_beat;

	assign req_key   = arb_req.addr[$bits(dram_addr_t)-1:BEAT_W];
	assign req_beat  = arb_req.addr.column[BEAT_W-1:0];
	assign fill_open = slot_q[fill_slot].state == slot_filling;
	// a taken beat position also forces a new burst, no overwrite
	assign merge = fill_open && slot_q[fill_slot].addr == req_key &&
		slot_q[fill_slot].kind == arb_req.kind && !slot_q[fill_slot].mask[req_beat];
	assign wr_slot = merge ? fill_slot : new_slot;

	assign slot_info.kind = slot_q[sel_slot].kind;
	assign slot_info.addr = slot_q[sel_slot].addr;
	assign wr_beat_data   = slot_q[sel_slot].data[beat_num];
	assign wr_beat_mask   = slot_q[sel_slot].mask[beat_num];

	always_comb begin
		new_slot   = '0;
		drain_slot = '0;
		drain_any  = 1'b0;
		free_slots = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin // downward so lowest wins
			full[i] = slot_q[i].state == slot_full;
			if (slot_q[i].state == slot_empty) begin
				new_slot   = SLOT_W'(i);
				free_slots = free_slots + 1'b1;
			end
			if (slot_q[i].state == slot_returning) begin
				drain_slot = SLOT_W'(i);
				drain_any  = 1'b1;
			end
		end
	end

	// isolate lowest pending beat of the draining slot
	always_comb begin
		low_bit  = slot_q[drain_slot].mask & (~slot_q[drain_slot].mask + 1'b1);
		ret_beat = '0;
		for (int b = 0; b < BURST_LEN; b++) begin
			if (low_bit[b]) ret_beat = BEAT_W'(b);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				slot_q[i].state <= slot_empty;
				slot_q[i].mask  <= '0;
			end
			fill_slot <= '0;
			ret_valid <= 1'b0;
		end else begin
			if (arbiter_valid) begin
				if (!merge) begin // close the open burst, start another
					if (fill_open) slot_q[fill_slot].state <= slot_full;
					slot_q[new_slot].state <= slot_filling;
					slot_q[new_slot].kind  <= arb_req.kind;
					slot_q[new_slot].addr  <= req_key;
					fill_slot <= new_slot;
				end
				slot_q[wr_slot].mask[req_beat]  <= 1'b1;
				slot_q[wr_slot].index[req_beat] <= arb_req.index;
				slot_q[wr_slot].data[req_beat]  <= arb_req.data; // reads overwritten by dq_in
			end else if (fill_open) begin
				slot_q[fill_slot].state <= slot_full; // idle cycle ends the burst
			end

			if (start_pulse) slot_q[sel_slot].state <= slot_busy;
			if (done_pulse) slot_q[sel_slot].state <= slot_returning;
			if (rd_beat_we && slot_q[sel_slot].mask[beat_num]) begin
				slot_q[sel_slot].data[beat_num] <= dq_in;
			end

			ret_valid <= 1'b0;
			if (drain_any) begin
				if (|low_bit) begin
					ret_valid <= 1'b1;
					ret.kind  <= slot_q[drain_slot].kind;
					ret.index <= slot_q[drain_slot].index[ret_beat];
					ret.data  <= slot_q[drain_slot].data[ret_beat];
					slot_q[drain_slot].mask[ret_beat] <= 1'b0;
				end else begin
					slot_q[drain_slot].state <= slot_empty; // all beats handed back
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [ddr5_pkg::NUM_SLOTS-1:0]     full,
	input  ddr5_pkg::slot_info_t               slot_info,
	input  logic                               expired,
	output logic [ddr5_pkg::SLOT_W-1:0]        sel_slot,
	output logic                               start_pulse,
	output logic                               done_pulse,
	output logic                               rd_beat_we,
	output logic                               wr_beat_valid,
	output logic [ddr5_pkg::BEAT_W-1:0]        beat_num,
	output logic                               load,
	output logic [ddr5_pkg::TIMER_W-1:0]       load_cycles,
	output ddr5_pkg::dram_cmd_t                cmd,
	output ddr5_pkg::burst_addr_t              cmd_addr
);
	import ddr5_pkg::*;

	typedef enum logic [2:0] {
		st_idle, st_act, st_trcd, st_col, st_lat, st_data, st_pre, st_done
	} seq_state_t;

	seq_state_t        state_q;
	logic [SLOT_W-1:0] pick;
	logic [BEAT_W-1:0] beat_q;
	logic              is_read;

	assign is_read = slot_info.kind == kind_read;

	always_comb begin
		pick = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (full[i]) pick = SLOT_W'(i);
		end
	end

	assign start_pulse   = state_q == st_act;
	assign done_pulse    = state_q == st_done;
	assign rd_beat_we    = state_q == st_data && is_read;
	assign wr_beat_valid = state_q == st_data && !is_read;
	assign beat_num      = beat_q;
	assign cmd_addr      = slot_info.addr;
	assign load          = state_q == st_act || state_q == st_col;

	// encoder adds one cycle to p1 and two to p2, timer expires count+1 after load.
	// write beats are launched a cycle early since the encoder registers dq_out
	always_comb begin
		if (state_q == st_act) load_cycles = TIMER_W'(T_RCD - 1);
		else if (is_read) load_cycles = TIMER_W'(RD_TO_DATA);
		else load_cycles = TIMER_W'(WR_TO_DATA - 1);
	end

	always_comb begin
		case (state_q)
			st_act:  cmd = cmd_activate;
			st_col:  cmd = is_read ? cmd_read : cmd_write;
			st_pre:  cmd = cmd_precharge;
			default: cmd = cmd_nop;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state_q  <= st_idle;
			sel_slot <= '0;
			beat_q   <= '0;
		end else begin
			case (state_q)
				st_idle: if (|full) begin
					sel_slot <= pick; // lowest full slot
					state_q  <= st_act;
				end
				st_act:  state_q <= st_trcd;
				st_trcd: if (expired) state_q <= st_col;
				st_col:  state_q <= st_lat;
				st_lat: begin
					beat_q <= '0;
					if (expired) state_q <= st_data;
				end
				st_data: begin
					beat_q <= beat_q + 1'b1;
					if (beat_q == BEAT_W'(BURST_LEN - 1)) state_q <= st_pre;
				end
				st_pre:  state_q <= st_done;
				default: state_q <= st_idle; // st_done
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/latency_timer.sv
`timescale 1ns/1ps
`default_nettype none

module latency_timer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          load,
	input  logic [ddr5_pkg::TIMER_W-1:0]  load_cycles,
	output logic                          expired
);
	import ddr5_pkg::*;

	logic [TIMER_W-1:0] count_q;

	// stays high from zero until the next load
	assign expired = count_q == '0;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			count_q <= '0;
		end else if (load) begin
			count_q <= load_cycles;
		end else if (!expired) begin
			count_q <= count_q - 1'b1; // hold at zero
		end
	end

endmodule

`default_nettype wire

//--- verilog/ca_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module ca_encoder (
	input  logic                          clk,
	input  logic                          rst_n,
	input  ddr5_pkg::dram_cmd_t           cmd,
	input  ddr5_pkg::burst_addr_t         cmd_addr,
	input  logic                          wr_beat_valid,
	input  logic [ddr5_pkg::DATA_W-1:0]   wr_beat_data,
	input  logic                          wr_beat_mask,
	output logic                          cs_n,
	output logic [ddr5_pkg::CA_W-1:0]     ca,
	output logic [ddr5_pkg::DATA_W-1:0]   dq_out,
	output logic                          dq_oe
);
	import ddr5_pkg::*;

	dram_cmd_t         cmd_q;  // command waiting for its p2 cycle
	burst_addr_t       addr_q;
	logic [CA_W-1:0]   p1_word;
	logic [CA_W-1:0]   p2_word;

	always_comb begin
		p1_word = '0;
		p2_word = '0;
		case (cmd)
			cmd_activate:  p1_word = {OP_ACT, cmd_addr.row[3:0], cmd_addr.bank,
				cmd_addr.bank_group, 4'b0000};
			cmd_read:      p1_word = {OP_RD, 1'b0, cmd_addr.bank, cmd_addr.bank_group, 4'b0000};
			cmd_write:     p1_word = {OP_WR, 1'b0, cmd_addr.bank, cmd_addr.bank_group, 4'b0000};
			cmd_precharge: p1_word = {1'b1, OP_PRE, 1'b0, cmd_addr.bank,
				cmd_addr.bank_group, 3'b000};
			default: ;
		endcase
		case (cmd_q)
			cmd_activate:        p2_word = {addr_q.row[15:4], 2'b00}; // upper row bits
			cmd_read, cmd_write: p2_word = {1'b0, addr_q.col_group, 7'b0000000};
			default: ; // precharge has no p2
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cmd_q <= cmd_nop;
			cs_n  <= 1'b1;
			ca    <= '0;
			dq_oe <= 1'b0;
		end else begin
			cmd_q <= cmd;
			if (cmd != cmd_nop) begin
				cs_n <= 1'b0; // p1
				ca   <= p1_word;
			end else begin
				cs_n <= 1'b1; // p2 or idle, p2_word is zero when idle
				ca   <= p2_word;
			end
			dq_oe <= wr_beat_valid && wr_beat_mask; // masked beats leave the bus floating
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= cmd_addr;
		if (wr_beat_valid) dq_out <= wr_beat_data;
	end

endmodule

`default_nettype wire

//--- verilog/ddr5_burst_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddr5_burst_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               arbiter_valid,
	input  ddr5_pkg::arb_req_t                 arb_req,
	input  logic [ddr5_pkg::DATA_W-1:0]        dq_in,
	output logic [ddr5_pkg::FREE_W-1:0]        free_slots,
	output logic                               cs_n,
	output logic [ddr5_pkg::CA_W-1:0]          ca,
	output logic [ddr5_pkg::DATA_W-1:0]        dq_out,
	output logic                               dq_oe,
	output logic                               ret_valid,
	output ddr5_pkg::ret_t                     ret
);
	import ddr5_pkg::*;

	logic [NUM_SLOTS-1:0] full;
	slot_info_t           slot_info;
	logic [SLOT_W-1:0]    sel_slot;
	logic                 start_pulse;
	logic                 done_pulse;
	logic                 rd_beat_we;
	logic                 wr_beat_valid;
	logic [BEAT_W-1:0]    beat_num;
	logic [DATA_W-1:0]    wr_beat_data;
	logic                 wr_beat_mask;
	logic                 load;
	logic [TIMER_W-1:0]   load_cycles;
	logic                 expired;
	dram_cmd_t            cmd;
	burst_addr_t          cmd_addr;

	burst_collector collector_i (
		.clk, .rst_n, .arbiter_valid, .arb_req, .sel_slot, .start_pulse, .done_pulse,
		.rd_beat_we, .beat_num, .dq_in, .free_slots, .full, .slot_info,
		.wr_beat_data, .wr_beat_mask, .ret_valid, .ret
	);

	cmd_sequencer sequencer_i (
		.clk, .rst_n, .full, .slot_info, .expired, .sel_slot, .start_pulse, .done_pulse,
		.rd_beat_we, .wr_beat_valid, .beat_num, .load, .load_cycles, .cmd, .cmd_addr
	);

	latency_timer timer_i (.clk, .rst_n, .load, .load_cycles, .expired);

	ca_encoder encoder_i (
		.clk, .rst_n, .cmd, .cmd_addr, .wr_beat_valid, .wr_beat_data, .wr_beat_mask,
		.cs_n, .ca, .dq_out, .dq_oe
	);

endmodule

`default_nettype wire

//--- tests/ddr5_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module ddr5_mem_model (
	input  logic                          clk,
	input  logic                          cs_n,
	input  logic [ddr5_pkg::CA_W-1:0]     ca,
	input  logic [ddr5_pkg::DATA_W-1:0]   dq_out,
	input  logic                          dq_oe,
	output logic [ddr5_pkg::DATA_W-1:0]   dq_in
);
	import ddr5_pkg::*;

	logic [DATA_W-1:0] mem [dram_addr_t]; // only written beats are stored
	dram_cmd_t         p1_cmd;            // command waiting for its p2 word
	logic [1:0]        bg;
	logic [1:0]        bk;
	logic [15:0]       row;
	logic [5:0]        col_group;
	logic              rd_on;
	logic              wr_on;
	int                wait_cnt;
	int                beat;

	function automatic dram_addr_t beat_addr(input int b);
		dram_addr_t a;
		a.bank_group = bg;
		a.bank       = bk;
		a.row        = row;
		a.column     = {col_group, BEAT_W'(b)};
		return a;
	endfunction

	initial begin
		dq_in    = '0;
		p1_cmd   = cmd_nop;
		rd_on    = 1'b0;
		wr_on    = 1'b0;
		wait_cnt = 0;
		beat     = 0;
	end

	// negedge so cs_n, ca and dq_out are stable, dq_in is settled before the next posedge
	always @(negedge clk) begin : model_step
		dram_addr_t a;
		if (rd_on || wr_on) begin
			if (wait_cnt > 0) begin
				wait_cnt--;
			end else begin
				a = beat_addr(beat);
				if (rd_on) dq_in <= mem.exists(a) ? mem[a] : a[DATA_W-1:0]; // default pattern
				else if (dq_oe) mem[a] = dq_out; // masked beats are not driven
				beat++;
				if (beat == BURST_LEN) begin
					rd_on = 1'b0;
					wr_on = 1'b0;
				end
			end
		end
		if (!cs_n) begin // p1 word
			if (ca[13:12] == OP_ACT) begin
				p1_cmd   = cmd_activate;
				row[3:0] = ca[11:8];
				bk       = ca[7:6];
				bg       = ca[5:4];
			end else if (ca[13:9] == OP_RD || ca[13:9] == OP_WR) begin
				p1_cmd = (ca[13:9] == OP_RD) ? cmd_read : cmd_write;
			end else begin
				p1_cmd = cmd_nop; // precharge, one cycle only
			end
		end else begin // p2 word or idle
			case (p1_cmd)
				cmd_activate: row[15:4] = ca[13:2];
				cmd_read, cmd_write: begin
					col_group = ca[12:7];
					rd_on     = p1_cmd == cmd_read;
					wr_on     = p1_cmd == cmd_write;
					wait_cnt  = (p1_cmd == cmd_read ? RD_TO_DATA : WR_TO_DATA) - 1;
					beat      = 0;
				end
				default: ;
			endcase
			p1_cmd = cmd_nop;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_ddr5_burst_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr5_burst_top;
	import ddr5_pkg::*;

	localparam int MAX_BURSTS     = 60; // 40 random requests plus the directed bursts
	localparam int TIMEOUT_CYCLES = MAX_BURSTS * 80 + 200;
	localparam int NUM_IDX        = 1 << INDEX_W;

	typedef struct packed {
		logic [15:0]       burst; // tb burst number
		logic [BEAT_W-1:0] beat;
		ret_t              exp;
	} exp_t;

	logic                 clk = 1'b0;
	logic                 rst_n = 1'b1; // active high reset
	logic                 arbiter_valid;
	arb_req_t             arb_req;
	logic [DATA_W-1:0]    dq_in;
	logic [FREE_W-1:0]    free_slots;
	logic                 cs_n;
	logic [CA_W-1:0]      ca;
	logic [DATA_W-1:0]    dq_out;
	logic                 dq_oe;
	logic                 ret_valid;
	ret_t                 ret;

	logic [DATA_W-1:0]    shadow [dram_addr_t]; // expected DRAM contents
	exp_t                 open_q [$];           // burst still filling
	exp_t                 pending [$];          // closed bursts, ascending beats
	burst_addr_t          open_key;
	req_kind_t            open_kind;
	logic [BURST_LEN-1:0] open_mask;
	logic [NUM_IDX-1:0]   idx_busy = '0;
	logic [FREE_W-1:0]    free_seen;
	int                   burst_cnt = 0;
	int                   cur_burst = -1;
	int                   next_idx = 0;
	int                   cycles = 0;
	bit                   opened_last = 1'b0;

	ddr5_burst_top dut_i (
		.clk, .rst_n, .arbiter_valid, .arb_req, .dq_in, .free_slots,
		.cs_n, .ca, .dq_out, .dq_oe, .ret_valid, .ret
	);

	ddr5_mem_model mem_i (.clk, .cs_n, .ca, .dq_out, .dq_oe, .dq_in);

	always #10 clk = ~clk;

	task automatic fail_run();
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_ret(input ret_t got, input ret_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: ret got kind=%0d index=%0d data=%h,",
				$time, got.kind, got.index, got.data);
			$display("   expected kind=%0d index=%0d data=%h", exp.kind, exp.index, exp.data);
			fail_run();
		end
	endtask

	task automatic check_free(input logic [FREE_W-1:0] got, input logic [FREE_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: free_slots got %0d, expected %0d", $time, got, exp);
			fail_run();
		end
	endtask

	// write returns its own data, read returns last write or the address pattern
	function automatic ret_t expected_ret(input arb_req_t r);
		ret_t e;
		e.kind  = r.kind;
		e.index = r.index;
		if (r.kind == kind_write) e.data = r.data;
		else if (shadow.exists(r.addr)) e.data = shadow[r.addr];
		else e.data = r.addr[DATA_W-1:0];
		return e;
	endfunction

	function automatic bit opens_slot(input arb_req_t r);
		return !(open_q.size() > 0 && r.addr[$bits(dram_addr_t)-1:BEAT_W] == open_key &&
			r.kind == open_kind && !open_mask[r.addr.column[BEAT_W-1:0]]);
	endfunction

	function automatic arb_req_t make_req(input req_kind_t kind, input logic [1:0] bank,
		input logic [15:0] row, input logic [5:0] cg, input int beat);
		arb_req_t r;
		r.addr.bank_group = 2'd1;
		r.addr.bank       = bank;
		r.addr.row        = row;
		r.addr.column     = {cg, BEAT_W'(beat)};
		r.kind            = kind;
		r.data            = kind == kind_write ? DATA_W'($urandom) : '0;
		r.index           = '0; // given out in send_req
		return r;
	endfunction

	// moves the open burst to pending, sorted by beat
	task automatic close_burst();
		if (open_q.size() > 0) begin
			for (int b = 0; b < BURST_LEN; b++) begin
				foreach (open_q[i]) if (open_q[i].beat == BEAT_W'(b)) pending.push_back(open_q[i]);
			end
			open_q.delete();
			burst_cnt++;
		end
	endtask

	task automatic track_request(input arb_req_t r);
		exp_t e;
		if (opens_slot(r)) begin
			close_burst();
			open_key  = r.addr[$bits(dram_addr_t)-1:BEAT_W];
			open_kind = r.kind;
			open_mask = '0;
		end
		open_mask[r.addr.column[BEAT_W-1:0]] = 1'b1;
		e.burst = 16'(burst_cnt);
		e.beat  = r.addr.column[BEAT_W-1:0];
		e.exp   = expected_ret(r);
		open_q.push_back(e);
		if (r.kind == kind_write) shadow[r.addr] = r.data;
		idx_busy[r.index] = 1'b1;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		arbiter_valid <= 1'b0;
		close_burst(); // idle ends the filling burst
		opened_last = 1'b0;
	endtask

	task automatic send_req(input arb_req_t r);
		arb_req_t q;
		q = r;
		while (idx_busy[next_idx]) idle_cycle();
		q.index = INDEX_W'(next_idx);
		@(posedge clk);
		// free_seen misses the request driven on the last edge
		while (opens_slot(q) && int'(free_seen) - int'(opened_last) <= 0) begin
			arbiter_valid <= 1'b0;
			close_burst();
			opened_last = 1'b0;
			@(posedge clk);
		end
		arbiter_valid <= 1'b1;
		arb_req       <= q;
		opened_last = opens_slot(q);
		track_request(q);
		next_idx = (next_idx + 1) % NUM_IDX;
	endtask

	task automatic wait_drain();
		idle_cycle();
		while (pending.size() != 0) @(posedge clk);
		@(negedge clk); // last slot empties one cycle after its last return
		check_free(free_slots, FREE_W'(NUM_SLOTS));
	endtask

	always @(negedge clk) begin : compare_returns
		int pos;
		free_seen = free_slots;
		if (!rst_n && free_slots > FREE_W'(NUM_SLOTS)) begin
			$display("** Error at %0t: free_slots got %0d, above %0d",
				$time, free_slots, NUM_SLOTS);
			fail_run();
		end
		if (!rst_n && ret_valid) begin
			if (cur_burst < 0) begin // first return picks the burst
				foreach (pending[i]) if (cur_burst < 0 && pending[i].exp.index == ret.index)
					cur_burst = pending[i].burst;
				if (cur_burst < 0) begin
					$display("return with index %0d matches no outstanding request", ret.index);
					fail_run();
				end
			end
			pos = -1;
			foreach (pending[i]) if (pos < 0 && pending[i].burst == 16'(cur_burst)) pos = i;
			check_ret(ret, pending[pos].exp);
			idx_busy[ret.index] = 1'b0;
			pending.delete(pos);
			pos = -1;
			foreach (pending[i]) if (pending[i].burst == 16'(cur_burst)) pos = i;
			if (pos < 0) cur_burst = -1; // burst fully returned
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d returns outstanding", cycles, pending.size());
			fail_run();
		end
	end

	initial begin : stimulus
		int beats [$];
		arb_req_t r;
		arbiter_valid = 1'b0;
		arb_req       = '0;
		void'($urandom(26));
		@(posedge clk);
		@(negedge clk);
		if (cs_n !== 1'b1 || dq_oe !== 1'b0 || ca !== '0 || ret_valid !== 1'b0) begin
			$display("outputs not at their reset values during reset");
			fail_run();
		end
		check_free(free_slots, FREE_W'(NUM_SLOTS));
		@(posedge clk);
		rst_n <= 1'b0; // 2 cycles of reset done

		// writes to one row then reads back
		for (int b = 0; b < 8; b++) send_req(make_req(kind_write, 2'd2, 16'h0123, 6'd3, b));
		wait_drain();
		for (int b = 0; b < 8; b++) send_req(make_req(kind_read, 2'd2, 16'h0123, 6'd3, b));
		wait_drain();

		// never written, default pattern
		beats = '{0, 3, 15};
		foreach (beats[i]) send_req(make_req(kind_read, 2'd0, 16'h0456, 6'd1, beats[i]));
		wait_drain();

		// scrambled beat order
		beats = '{9, 2, 14, 5, 0};
		foreach (beats[i]) send_req(make_req(kind_write, 2'd3, 16'h0123, 6'd5, beats[i]));
		wait_drain();
		beats = '{14, 0, 7, 9, 5, 2}; // beat 7 was masked in the write burst
		foreach (beats[i]) send_req(make_req(kind_read, 2'd3, 16'h0123, 6'd5, beats[i]));
		wait_drain();

		// kind change, key change, idle and a repeated beat all close bursts
		send_req(make_req(kind_write, 2'd1, 16'h0777, 6'd0, 1));
		send_req(make_req(kind_write, 2'd1, 16'h0777, 6'd0, 2));
		send_req(make_req(kind_read, 2'd1, 16'h0777, 6'd0, 3));
		send_req(make_req(kind_read, 2'd1, 16'h0777, 6'd2, 4));
		idle_cycle();
		send_req(make_req(kind_read, 2'd1, 16'h0777, 6'd2, 6));
		send_req(make_req(kind_read, 2'd1, 16'h0777, 6'd2, 6));
		wait_drain();

		// random mix, reads and writes on separate rows
		for (int n = 0; n < 40; n++) begin
			if ($urandom_range(1) == 0)
				r = make_req(kind_read, 2'($urandom_range(1)), 16'h0a00 + 16'($urandom_range(1)),
					6'($urandom_range(1)), $urandom_range(BURST_LEN - 1));
			else
				r = make_req(kind_write, 2'($urandom_range(1)), 16'h0b00 + 16'($urandom_range(1)),
					6'($urandom_range(1)), $urandom_range(BURST_LEN - 1));
			send_req(r);
			if ($urandom_range(7) == 0) idle_cycle();
		end
		wait_drain();

		if (pending.size() == 0 && open_q.size() == 0 && idx_busy == '0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("%0d returns missing at end of run", pending.size() + open_q.size());
			fail_run();
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
verilog/ddr5_pkg.sv
verilog/burst_collector.sv
verilog/cmd_sequencer.sv
verilog/latency_timer.sv
verilog/ca_encoder.sv
verilog/ddr5_burst_top.sv
tests/ddr5_mem_model.sv
tests/tb_ddr5_burst_top.sv

//--- Makefile
# Verilator build and run of the DDR5 burst engine testbench

VERILATOR ?= verilator
TOP       ?= tb_ddr5_burst_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless TEST PASSED is printed"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
